// ==== src/mpram_params.svh ====
////////////////////////////////////////////////////////////
// Bank depth must be a power of two. Data width is a
// multiple of 8 and at least 16 bits
////////////////////////////////////////////////////////////

`ifndef MPRAM_PARAMS_SVH
`define MPRAM_PARAMS_SVH

// Number of independent AHB ports
`define MPRAM_PORTS 2

// Bus widths
`define MPRAM_XLEN 32
`define MPRAM_PLEN 32

// Words per bank
`define MPRAM_DEPTH 64

// Derived sizes
`define MPRAM_BE_SIZE ((`MPRAM_XLEN + 7) / 8)
`define MPRAM_ABITS $clog2(`MPRAM_DEPTH)

`endif

// ==== src/ahb3_pkg.sv ====
////////////////////////////////////////////////////////////
// AHB-Lite encodings only. No HRESP, HBURST or HPROT
////////////////////////////////////////////////////////////

package ahb3_pkg;

  // HTRANS transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // HSIZE transfer size up to a 1024-bit bus
  // Sizes wider than the data bus enable every lane
  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010,
    DWORD = 3'b011,
    B128  = 3'b100,
    B256  = 3'b101,
    B512  = 3'b110,
    B1024 = 3'b111
  } hsize_t;

endpackage

// ==== src/mpram_pkg.sv ====
////////////////////////////////////////////////////////////
// Memory side types. Sizes follow the params header
////////////////////////////////////////////////////////////

`include "mpram_params.svh"

package mpram_pkg;

  // One enable bit per byte lane
  typedef logic [`MPRAM_BE_SIZE-1:0] be_t;

  // Word address into one bank
  // Upper byte address bits are dropped so accesses wrap
  typedef logic [`MPRAM_ABITS-1:0] mem_addr_t;

  // Data phase state of a port
  //   PH_IDLE   no transfer outstanding
  //   PH_READ   read data on hrdata
  //   PH_WRITE  write data being taken
  //   PH_STALL  one wait state after a partial write hit
  typedef enum logic [1:0] {
    PH_IDLE  = 2'b00,
    PH_READ  = 2'b01,
    PH_WRITE = 2'b10,
    PH_STALL = 2'b11
  } port_phase_t;

endpackage

// ==== src/mpram_ahb3_port.sv ====
////////////////////////////////////////////////////////////
// AHB-Lite slave front end for one bank. Expects hready to
// follow this port's hreadyout while a stall is active
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "mpram_params.svh"

module mpram_ahb3_port
  import ahb3_pkg::*, mpram_pkg::*;
(
  input  logic                   HCLK,
  input  logic                   HRESETn,

  // AHB address phase
  input  logic                   hsel,
  input  logic [`MPRAM_PLEN-1:0] haddr,
  input  logic                   hwrite,
  input  hsize_t                 hsize,
  input  htrans_t                htrans,
  input  logic                   hready,
  output logic                   hreadyout,

  // Bank write side
  output logic                   we,
  output mem_addr_t              waddr,
  output be_t                    be,

  // Bank read side
  output mem_addr_t              raddr
);

  // Byte offset bits within a word
  localparam int OFS_BITS = $clog2(`MPRAM_BE_SIZE);

  logic        accept;
  logic        rd_hit;
  logic        stall;
  logic        hold;
  mem_addr_t   word_addr;
  mem_addr_t   rd_addr_q;
  port_phase_t phase;

  ////////////////////////////////////////////////////////////
  // Byte enable decode
  ////////////////////////////////////////////////////////////

  // Lane mask for the size, shifted to the byte offset
  function automatic be_t gen_be(input hsize_t size, input logic [OFS_BITS-1:0] offset);
    logic [127:0] lanes;

    // 2**size lanes set, all lanes for 1024 bits
    lanes = (128'd1 << (8'd1 << size)) - 128'd1;
    return lanes[`MPRAM_BE_SIZE-1:0] << offset;
  endfunction

  ////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////

  // Only NONSEQ and SEQ carry a transfer
  assign accept = hsel & hready & ((htrans == NONSEQ) | (htrans == SEQ));

  // Word index, upper bits dropped so the address wraps
  assign word_addr = haddr[OFS_BITS +: `MPRAM_ABITS];

  // Read to the word whose write lands at this same edge
  assign rd_hit = accept & ~hwrite & we & (waddr == word_addr);

  // Bank forwards full words only
  // A partial write needs one more cycle for the merged word
  assign stall = rd_hit & ~(&be);

  ////////////////////////////////////////////////////////////
  // Write capture
  ////////////////////////////////////////////////////////////

  // Write strobe for the data phase
  // Dropped when no transfer is accepted
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      we <= 1'b0;
    end else begin
      we <= accept & hwrite;
    end
  end

  // Write address and lanes of the accepted transfer
  always_ff @(posedge HCLK) begin
    if (accept) begin
      waddr <= word_addr;
      be    <= gen_be(hsize, haddr[OFS_BITS-1:0]);
    end
  end

  ////////////////////////////////////////////////////////////
  // Data phase state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      phase <= PH_IDLE;
    end else if (accept) begin
      if (hwrite) begin
        phase <= PH_WRITE;
      end else if (stall) begin
        phase <= PH_STALL;
      end else begin
        phase <= PH_READ;
      end
    end else if (phase == PH_STALL) begin
      // Re-read issued, data follows next cycle
      phase <= PH_READ;
    end else if (hready) begin
      phase <= PH_IDLE;
    end
  end

  // Single wait state while stalled
  assign hreadyout = (phase != PH_STALL);

  ////////////////////////////////////////////////////////////
  // Read address
  ////////////////////////////////////////////////////////////

  // Keep the last read address while the data phase is held
  // Bank re-reads it so hrdata stays valid
  assign hold = (phase == PH_STALL) | ~hready;

  assign raddr = hold ? rd_addr_q : word_addr;

  // Tracks the address given to the bank each cycle
  always_ff @(posedge HCLK) begin
    rd_addr_q <= raddr;
  end

endmodule

// ==== src/mpram_bank_1r1w.sv ====
////////////////////////////////////////////////////////////
// Byte-writable bank with a registered read. No reset so
// contents are undefined until written
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "mpram_params.svh"

module mpram_bank_1r1w
  import mpram_pkg::*;
(
  input  logic                   HCLK,

  // Write side, data arrives in the AHB data phase
  input  logic                   we,
  input  mem_addr_t              waddr,
  input  be_t                    be,
  input  logic [`MPRAM_XLEN-1:0] din,

  // Read side, sampled every cycle
  input  mem_addr_t              raddr,
  output logic [`MPRAM_XLEN-1:0] dout
);

  // Storage array
  logic [`MPRAM_XLEN-1:0] mem [`MPRAM_DEPTH];

  // Same-word collision with every lane written
  logic fwd;

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  // Only enabled lanes change
  always_ff @(posedge HCLK) begin
    if (we) begin
      for (int i = 0; i < `MPRAM_BE_SIZE; i++) begin
        if (be[i]) begin
          mem[waddr][i*8 +: 8] <= din[i*8 +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////

  // Full word written this edge, so din is the new content
  assign fwd = we & (&be) & (waddr == raddr);

  // Registered read
  // Partial collision returns the old word and the port stalls
  always_ff @(posedge HCLK) begin
    if (fwd) begin
      dout <= din;
    end else begin
      dout <= mem[raddr];
    end
  end

endmodule

// ==== src/mpram_ahb3.sv ====
////////////////////////////////////////////////////////////
// One front end and one bank per AHB port. Ports never
// share storage and run fully in parallel
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "mpram_params.svh"

module mpram_ahb3
  import ahb3_pkg::*, mpram_pkg::*;
(
  input  logic                                      HCLK,
  input  logic                                      HRESETn,

  // AHB-Lite slave ports, one slice per port
  input  logic    [`MPRAM_PORTS-1:0]                hsel,
  input  logic    [`MPRAM_PORTS-1:0][`MPRAM_PLEN-1:0] haddr,
  input  logic    [`MPRAM_PORTS-1:0][`MPRAM_XLEN-1:0] hwdata,
  output logic    [`MPRAM_PORTS-1:0][`MPRAM_XLEN-1:0] hrdata,
  input  logic    [`MPRAM_PORTS-1:0]                hwrite,
  input  hsize_t  [`MPRAM_PORTS-1:0]                hsize,
  input  htrans_t [`MPRAM_PORTS-1:0]                htrans,
  input  logic    [`MPRAM_PORTS-1:0]                hready,
  output logic    [`MPRAM_PORTS-1:0]                hreadyout
);

  for (genvar t = 0; t < `MPRAM_PORTS; t++) begin : g_port
    // Front end to bank
    logic      we;
    mem_addr_t waddr;
    be_t       be;
    mem_addr_t raddr;

    // AHB decode, write capture and stall
    mpram_ahb3_port u_port (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .hsel      (hsel[t]),
      .haddr     (haddr[t]),
      .hwrite    (hwrite[t]),
      .hsize     (hsize[t]),
      .htrans    (htrans[t]),
      .hready    (hready[t]),
      .hreadyout (hreadyout[t]),
      .we        (we),
      .waddr     (waddr),
      .be        (be),
      .raddr     (raddr)
    );

    // Write data straight from the bus, read data straight back
    mpram_bank_1r1w u_bank (
      .HCLK  (HCLK),
      .we    (we),
      .waddr (waddr),
      .be    (be),
      .din   (hwdata[t]),
      .raddr (raddr),
      .dout  (hrdata[t])
    );
  end

endmodule

// ==== tests/tb_clock.sv ====
////////////////////////////////////////////////////////////
// 20 ns clock, reset low for the first two rising edges
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock (
  output logic HCLK,
  output logic HRESETn
);

  initial begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  // Release a little after the second edge
  initial begin
    HRESETn = 1'b0;
    repeat (2) @(posedge HCLK);
    #1 HRESETn = 1'b1;
  end

endmodule

// ==== tests/mpram_scoreboard.sv ====
////////////////////////////////////////////////////////////
// Watches every port, keeps a shadow byte array per bank.
// Reads are compared as full words at data phase completion
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "mpram_params.svh"

module mpram_scoreboard
  import ahb3_pkg::*, mpram_pkg::*;
(
  input logic                                      HCLK,
  input logic                                      HRESETn,
  input logic    [`MPRAM_PORTS-1:0]                hsel,
  input logic    [`MPRAM_PORTS-1:0][`MPRAM_PLEN-1:0] haddr,
  input logic    [`MPRAM_PORTS-1:0][`MPRAM_XLEN-1:0] hwdata,
  input logic    [`MPRAM_PORTS-1:0][`MPRAM_XLEN-1:0] hrdata,
  input logic    [`MPRAM_PORTS-1:0]                hwrite,
  input hsize_t  [`MPRAM_PORTS-1:0]                hsize,
  input htrans_t [`MPRAM_PORTS-1:0]                htrans,
  input logic    [`MPRAM_PORTS-1:0]                hready,
  input logic    [`MPRAM_PORTS-1:0]                hreadyout
);

  // Shadow content, one byte per lane
  logic [7:0] shadow [`MPRAM_PORTS][`MPRAM_DEPTH][`MPRAM_BE_SIZE];

  // Outstanding data phase per port
  logic                   pend_v    [`MPRAM_PORTS];
  logic                   pend_wr   [`MPRAM_PORTS];
  logic [`MPRAM_PLEN-1:0] pend_addr [`MPRAM_PORTS];
  hsize_t                 pend_size [`MPRAM_PORTS];

  string test_name = "none";
  int    checks = 0;
  int    errors = 0;

  function automatic int word_index(input logic [`MPRAM_PLEN-1:0] a);
    return int'((a / `MPRAM_BE_SIZE) % `MPRAM_DEPTH);
  endfunction

  // Merge a write into the shadow: 2**size lanes from the offset
  function automatic void apply_write(input int p, input logic [`MPRAM_PLEN-1:0] a,
                                      input hsize_t s, input logic [`MPRAM_XLEN-1:0] d);
    int nbytes;
    int off;
    int lane;

    nbytes = 1 << int'(s);
    if (nbytes > `MPRAM_BE_SIZE) nbytes = `MPRAM_BE_SIZE;
    off = int'(a % `MPRAM_BE_SIZE);
    for (int i = 0; i < nbytes; i++) begin
      lane = off + i;
      if (lane < `MPRAM_BE_SIZE) begin
        shadow[p][word_index(a)][lane] = d[lane*8 +: 8];
      end
    end
  endfunction

  // Reference: the word the bank must return for this address
  function automatic logic [`MPRAM_XLEN-1:0] expected_word(input int p,
                                                         input logic [`MPRAM_PLEN-1:0] a);
    logic [`MPRAM_XLEN-1:0] w;

    for (int i = 0; i < `MPRAM_BE_SIZE; i++) begin
      w[i*8 +: 8] = shadow[p][word_index(a)][i];
    end
    return w;
  endfunction

  task automatic check_value(input string name, input logic [`MPRAM_XLEN-1:0] exp,
                             input logic [`MPRAM_XLEN-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("Failure in %s: %s", test_name, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // Comparing process
  ////////////////////////////////////////////////////////////

  // Completion first, then the new address phase of the same edge
  always @(posedge HCLK) begin
    for (int p = 0; p < `MPRAM_PORTS; p++) begin
      if (!HRESETn) begin
        pend_v[p] = 1'b0;
      end else begin
        if (pend_v[p] && hready[p] && hreadyout[p]) begin
          if (pend_wr[p]) begin
            apply_write(p, pend_addr[p], pend_size[p], hwdata[p]);
          end else begin
            check_value($sformatf("%s port %0d addr %h", test_name, p, pend_addr[p]),
                        expected_word(p, pend_addr[p]), hrdata[p]);
          end
          pend_v[p] = 1'b0;
        end
        if (hsel[p] && hready[p] && (htrans[p] == NONSEQ || htrans[p] == SEQ)) begin
          pend_v[p]    = 1'b1;
          pend_wr[p]   = hwrite[p];
          pend_addr[p] = haddr[p];
          pend_size[p] = hsize[p];
        end
      end
    end
  end

endmodule

// ==== tests/mpram_ahb3_chk.sv ====
////////////////////////////////////////////////////////////
// Handshake assertions, bound into every port front end
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mpram_ahb3_chk
  import ahb3_pkg::*, mpram_pkg::*;
(
  input logic        HCLK,
  input logic        HRESETn,
  input logic        hsel,
  input logic        hready,
  input htrans_t     htrans,
  input logic        hreadyout,
  input logic        we,
  input port_phase_t phase
);

  // Reset state: ready, no write strobe, idle phase
  a_ready_in_reset: assert property (@(posedge HCLK)
    !HRESETn |-> (hreadyout && !we && (phase == PH_IDLE)))
    else $error("port not ready and idle during reset");

  // One wait state at most
  a_short_stall: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !hreadyout |=> hreadyout)
    else $error("stall longer than one cycle");

  // No write strobe without an accepted transfer
  a_we_accept: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !(hsel && hready && (htrans == NONSEQ || htrans == SEQ)) |=> !we)
    else $error("we high after unaccepted transfer");

endmodule

bind mpram_ahb3_port mpram_ahb3_chk u_chk (
  .HCLK      (HCLK),
  .HRESETn   (HRESETn),
  .hsel      (hsel),
  .hready    (hready),
  .htrans    (htrans),
  .hreadyout (hreadyout),
  .we        (we),
  .phase     (phase)
);

// ==== tests/tb_mpram_ahb3.sv ====
////////////////////////////////////////////////////////////
// Drives both ports one after another. hready follows each
// port's hreadyout and can be pulled low at random
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "mpram_params.svh"

module tb_mpram_ahb3
  import ahb3_pkg::*, mpram_pkg::*;
;

  localparam int TIMEOUT = 50;
  localparam int SPAN    = `MPRAM_DEPTH * `MPRAM_BE_SIZE;

  logic HCLK;
  logic HRESETn;
  logic    [`MPRAM_PORTS-1:0]                hsel;
  logic    [`MPRAM_PORTS-1:0][`MPRAM_PLEN-1:0] haddr;
  logic    [`MPRAM_PORTS-1:0][`MPRAM_XLEN-1:0] hwdata;
  logic    [`MPRAM_PORTS-1:0][`MPRAM_XLEN-1:0] hrdata;
  logic    [`MPRAM_PORTS-1:0]                hwrite;
  hsize_t  [`MPRAM_PORTS-1:0]                hsize;
  htrans_t [`MPRAM_PORTS-1:0]                htrans;
  logic    [`MPRAM_PORTS-1:0]                hready;
  logic    [`MPRAM_PORTS-1:0]                hreadyout;

  // Chance in percent of an extra low hready cycle
  int hold_pct = 0;

  tb_clock u_clk (.HCLK(HCLK), .HRESETn(HRESETn));

  mpram_ahb3 uut (.*);

  mpram_scoreboard sb (.*);

  // Bus HREADY, low during a stall or a random hold
  initial hready = '1;
  always @(posedge HCLK) begin
    #1;
    for (int p = 0; p < `MPRAM_PORTS; p++) begin
      hready[p] = hreadyout[p] & !(hold_pct != 0 && $urandom_range(99) < hold_pct);
    end
  end

  // Address phase, returns 1 ns after the accepting edge
  task automatic issue(input int p, input logic wr, input logic [`MPRAM_PLEN-1:0] a,
                       input hsize_t s, input logic [`MPRAM_XLEN-1:0] d);
    int n;

    hsel[p]   = 1'b1;
    htrans[p] = NONSEQ;
    haddr[p]  = a;
    hwrite[p] = wr;
    hsize[p]  = s;
    n = 0;
    do begin
      @(posedge HCLK);
      n++;
    end while (!hready[p] && n < TIMEOUT);
    if (!hready[p]) sb.report_failure("transfer never accepted");
    #1;
    hsel[p]   = 1'b0;
    htrans[p] = IDLE;
    // Write data for the data phase just started
    if (wr) hwdata[p] = d;
  endtask

  // Let the last data phase complete
  task automatic drain(input int p);
    int n;

    n = 0;
    do begin
      @(posedge HCLK);
      n++;
    end while (!hready[p] && n < TIMEOUT);
    if (!hready[p]) sb.report_failure("data phase never completed");
    #1;
  endtask

  // Write then read the same word, count wait states
  task automatic write_read(input int p, input logic [`MPRAM_PLEN-1:0] a, input hsize_t s,
                            input int exp_stall);
    int n;

    issue(p, 1'b1, a, s, $urandom);
    issue(p, 1'b0, a & ~(`MPRAM_BE_SIZE - 1), WORD, '0);
    n = 0;
    while (!hreadyout[p] && n < TIMEOUT) begin
      @(posedge HCLK);
      #1;
      n++;
    end
    sb.check_value($sformatf("%s stall cycles", sb.test_name), exp_stall, n);
    drain(p);
  endtask

  initial begin
    int n;
    int op;
    logic [`MPRAM_PLEN-1:0] a;
    hsize_t s;

    void'($urandom(32'h0ce1_af0f));
    hsel   = '0;
    haddr  = '0;
    hwdata = '0;
    hwrite = '0;
    for (int p = 0; p < `MPRAM_PORTS; p++) begin
      hsize[p]  = WORD;
      htrans[p] = IDLE;
    end

    // Wait for reset release
    n = 0;
    while (HRESETn !== 1'b1 && n < TIMEOUT) begin
      @(posedge HCLK);
      n++;
    end
    if (HRESETn !== 1'b1) sb.report_failure("reset never released");
    @(posedge HCLK);
    #1;

    // Fill every word, then read all back
    sb.test_name = "fill_readback";
    for (int p = 0; p < `MPRAM_PORTS; p++) begin
      for (int w = 0; w < `MPRAM_DEPTH; w++) issue(p, 1'b1, w * 4, WORD, $urandom);
      for (int w = 0; w < `MPRAM_DEPTH; w++) issue(p, 1'b0, w * 4, WORD, '0);
      drain(p);
    end

    // Byte and halfword lanes at every offset
    sb.test_name = "lane_merge";
    for (int p = 0; p < `MPRAM_PORTS; p++) begin
      for (int o = 0; o < 4; o++) issue(p, 1'b1, 32'h40 + o, BYTE, $urandom);
      issue(p, 1'b0, 32'h40, WORD, '0);
      for (int o = 0; o < 4; o += 2) issue(p, 1'b1, 32'h44 + o, HWORD, $urandom);
      issue(p, 1'b0, 32'h44, WORD, '0);
      drain(p);
    end

    // Back to back write and read of one word
    sb.test_name = "full_forward";
    write_read(0, 32'h10, WORD, 0);
    write_read(1, 32'h14, WORD, 0);
    sb.test_name = "partial_stall";
    write_read(0, 32'h21, BYTE, 1);
    write_read(1, 32'h32, HWORD, 1);

    // Same address, different data, per bank
    sb.test_name = "bank_split";
    issue(0, 1'b1, 32'h80, WORD, 32'h1111_aaaa);
    drain(0);
    issue(1, 1'b1, 32'h80, WORD, 32'h2222_bbbb);
    drain(1);
    issue(0, 1'b0, 32'h80, WORD, '0);
    drain(0);
    issue(1, 1'b0, 32'h80, WORD, '0);
    drain(1);

    // Random traffic, wrapped addresses, idle, busy and holds
    sb.test_name = "random_mix";
    hold_pct = 25;
    for (int p = 0; p < `MPRAM_PORTS; p++) begin
      for (int i = 0; i < 200; i++) begin
        op = $urandom_range(3);
        a  = $urandom_range(4 * SPAN - 1);
        if (op == 0) begin
          hsel[p]   = $urandom_range(1);
          htrans[p] = hsel[p] ? BUSY : IDLE;
          @(posedge HCLK);
          #1;
          hsel[p]   = 1'b0;
          htrans[p] = IDLE;
        end else if (op == 1) begin
          issue(p, 1'b0, a & ~(`MPRAM_BE_SIZE - 1), WORD, '0);
        end else begin
          s = hsize_t'($urandom_range(2));
          issue(p, 1'b1, a & ~((1 << int'(s)) - 1), s, $urandom);
        end
      end
      drain(p);
    end
    hold_pct = 0;
    repeat (3) @(posedge HCLK);

    $display("Checks: %0d, errors: %0d", sb.checks, sb.errors);
    if (sb.errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+src
src/ahb3_pkg.sv
src/mpram_pkg.sv
src/mpram_ahb3_port.sv
src/mpram_bank_1r1w.sv
src/mpram_ahb3.sv
tests/tb_clock.sv
tests/mpram_scoreboard.sv
tests/mpram_ahb3_chk.sv
tests/tb_mpram_ahb3.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_mpram_ahb3 -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -x "Testbench passed" > /dev/null \
  && echo "Simulation run OK" \
  || { echo "Simulation run FAILED"; exit 1; }
